// File: compile.f
source/ll_pkg.sv
source/link_online_seq.sv
source/ll_credit_tx.sv
source/ll_rx_fifo.sv
source/phy_word_pack.sv
source/packet_master_top.sv
tests/tb_clock.sv
tests/packet_master_checker.sv
tests/packet_master_tb.sv

// File: Bender.yml
package:
  name: packet_master

sources:
  - files:
      - source/ll_pkg.sv
      - source/link_online_seq.sv
      - source/ll_credit_tx.sv
      - source/ll_rx_fifo.sv
      - source/phy_word_pack.sv
      - source/packet_master_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/packet_master_checker.sv
      - tests/packet_master_tb.sv

// File: tests/packet_master_tb.sv
/*
  Testbench for the packet master
  Far-end PHY model, AR and R stimulus from an LFSR
  Reference packing of AR words, falling-edge compare process, watchdog
*/
`timescale 1ns/1ps

module packet_master_tb;
  import ll_pkg::*;

  localparam int CLK_NS       = 4;
  localparam int ONLINE_DELAY = 5;
  localparam int WAIT_LIMIT   = 40;
  localparam int AR_RANDOM    = 16;
  localparam int R_BEATS      = 40;
  localparam int R_LOOP_LIMIT = 20 * R_BEATS;
  // Tests 1, 3, 2, 4, 5 in run order, then slack
  localparam int RUN_CYCLES = (ONLINE_DELAY + 10) + 40 + AR_RANDOM * (WAIT_LIMIT + 4)
                            + R_LOOP_LIMIT + (2 * WAIT_LIMIT + 30) + 100;
  localparam logic [PHY_W-1:0] CRED_MASK = PHY_W'(1) << TX_R_CRED_BIT;

  logic               clk_wr;
  logic               rst_n;
  logic               tx_online;
  logic               rx_online;
  logic [DELAY_W-1:0] delay_value;
  logic [CRED_W-1:0]  init_ar_credit;
  logic [ID_W-1:0]    arid;
  logic [SIZE_W-1:0]  arsize;
  logic [LEN_W-1:0]   arlen;
  logic [BURST_W-1:0] arburst;
  logic [ADDR_W-1:0]  araddr;
  logic               arvalid;
  logic               arready;
  logic [ID_W-1:0]    rid;
  logic [DATA_W-1:0]  rdata;
  logic               rlast;
  logic [RESP_W-1:0]  rresp;
  logic               rvalid;
  logic               rready;
  logic [PHY_W-1:0]   tx_phy;
  logic [PHY_W-1:0]   rx_phy;

  // Scoreboard queues and far-end state
  logic [PHY_W-1:0] exp_ar[$];
  int               exp_ar_due[$];
  logic [R_W-1:0]   exp_r[$];
  logic [31:0]      lfsr;
  logic             pop_prev = 1'b0;
  int               far_r_credit;
  int               neg_cyc = 0;
  int               r_pops = 0;
  int               r_creds = 0;
  int               mismatches = 0;
  int               problems = 0;

  tb_clock u_clk (.clk_wr(clk_wr));

  packet_master_top dut (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[126:0], lfsr[0]};
    end
    return r;
  endfunction

  // Expected tx_phy word for an accepted AR request, credit bit excluded
  function automatic logic [PHY_W-1:0] ar_phy_word(
    input logic [ID_W-1:0] id, input logic [SIZE_W-1:0] size, input logic [LEN_W-1:0] len,
    input logic [BURST_W-1:0] burst, input logic [ADDR_W-1:0] addr);
    logic [PHY_W-1:0] w;
    w                        = '0;
    w[TX_AR_PUSH_BIT]        = 1'b1;
    w[TX_AR_LSB +: AR_W]     = {id, size, len, burst, addr};
    return w;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    mismatches++;
  endtask

  task automatic report_problem(input string msg);
    $display("At %0t: %s", $time, msg);
    problems++;
  endtask

  //////////////////////////////////////////////////
  // Far end and user-side drivers, called at a rising edge

  task automatic drive_random_ar();
    arid    <= ID_W'(rand_bits(ID_W));
    arsize  <= SIZE_W'(rand_bits(SIZE_W));
    arlen   <= LEN_W'(rand_bits(LEN_W));
    arburst <= BURST_W'(rand_bits(BURST_W));
    araddr  <= ADDR_W'(rand_bits(ADDR_W));
    arvalid <= 1'b1;
  endtask

  task automatic send_random_r_beat();
    logic [R_W-1:0]   beat;
    logic [PHY_W-1:0] word;
    beat                    = R_W'(rand_bits(R_W));
    word                    = '0;
    word[RX_R_PUSH_BIT]     = 1'b1;
    word[RX_R_LSB +: R_W]   = beat;
    rx_phy                 <= word;
    exp_r.push_back(beat);
    far_r_credit--;
  endtask

  task automatic return_ar_credit();
    @(posedge clk_wr);
    rx_phy <= PHY_W'(1) << RX_AR_CRED_BIT;
    @(posedge clk_wr);
    rx_phy <= '0;
  endtask

  // Keep arvalid up for a number of cycles, new request after each acceptance
  task automatic stream_ar(input int cycles, output int accepted);
    logic hs;
    accepted = 0;
    @(posedge clk_wr);
    drive_random_ar();
    repeat (cycles) begin
      @(negedge clk_wr);
      hs = arready;
      @(posedge clk_wr);
      if (hs) begin
        accepted++;
        drive_random_ar();
      end
    end
    arvalid <= 1'b0;
  endtask

  task automatic send_one_ar();
    int waited;
    waited = 0;
    @(posedge clk_wr);
    drive_random_ar();
    @(negedge clk_wr);
    while (!arready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk_wr);
    end
    if (!arready) begin
      report_problem("AR request was not accepted in time");
    end
    @(posedge clk_wr);
    arvalid <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Compare process at falling edges

  always @(negedge clk_wr) begin
    if (rst_n) begin
      neg_cyc++;
      if (tx_phy[TX_AR_PUSH_BIT]) begin
        if (exp_ar.size() == 0) begin
          report_problem("AR word on tx_phy without an accepted request");
        end else if ((tx_phy & ~CRED_MASK) !== exp_ar[0] || exp_ar_due[0] != neg_cyc) begin
          report_mismatch($sformatf("tx_phy %h in cycle %0d, expected %h in cycle %0d",
                                    tx_phy, neg_cyc, exp_ar[0], exp_ar_due[0]));
        end
      end else if ((tx_phy & ~CRED_MASK) !== '0) begin
        report_mismatch($sformatf("idle tx_phy carries stray bits %h", tx_phy));
      end
      if (exp_ar_due.size() != 0 && exp_ar_due[0] <= neg_cyc) begin
        if (!tx_phy[TX_AR_PUSH_BIT]) begin
          report_problem("An accepted AR request never reached tx_phy");
        end
        void'(exp_ar.pop_front());
        void'(exp_ar_due.pop_front());
      end
      // R credit bit follows each pop by one cycle
      if (tx_phy[TX_R_CRED_BIT] !== pop_prev) begin
        report_mismatch($sformatf("R credit bit %b after pop %b", tx_phy[TX_R_CRED_BIT], pop_prev));
      end
      if (tx_phy[TX_R_CRED_BIT]) begin
        r_creds++;
        far_r_credit++;
      end
      if (arvalid && arready) begin
        exp_ar.push_back(ar_phy_word(arid, arsize, arlen, arburst, araddr));
        exp_ar_due.push_back(neg_cyc + 1);
      end
      pop_prev = rvalid && rready;
      if (pop_prev) begin
        r_pops++;
        if (exp_r.size() == 0) begin
          report_problem("R beat delivered that the far end never sent");
        end else begin
          if ({rid, rdata, rlast, rresp} !== exp_r[0]) begin
            report_mismatch($sformatf("R beat %h, expected %h",
                                      {rid, rdata, rlast, rresp}, exp_r[0]));
          end
          void'(exp_r.pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    int sent;
    int cycles;
    int waited;
    int taken;
    lfsr           = 32'h0993c05b;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_value    = DELAY_W'(ONLINE_DELAY);
    init_ar_credit = CRED_W'(3);
    arid           = '0;
    arsize         = '0;
    arlen          = '0;
    arburst        = '0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    rx_phy         = '0;
    far_r_credit   = R_FIFO_DEPTH;
    repeat (2) @(posedge clk_wr);
    rst_n <= 1'b1;
    @(negedge clk_wr);
    if ({arready, rvalid} !== 2'b00 || tx_phy !== '0) begin
      report_mismatch("outputs not idle after reset");
    end

    // 1: online delay, inputs seen one edge later, link up 1 + delay edges after that
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    for (int i = 1; i <= ONLINE_DELAY + 6; i++) begin
      @(negedge clk_wr);
      if (arready !== (i >= ONLINE_DELAY + 3)) begin
        report_mismatch($sformatf("arready %b in cycle %0d after online", arready, i));
      end
    end

    // 3: credit limit
    stream_ar(12, taken);
    if (taken != 3) begin
      report_mismatch($sformatf("%0d requests taken on 3 credits", taken));
    end
    repeat (2) begin
      return_ar_credit();
      stream_ar(8, taken);
      if (taken != 1) begin
        report_mismatch($sformatf("%0d requests taken on 1 returned credit", taken));
      end
    end

    // 2: random requests, far end returns one credit each
    for (int i = 0; i < AR_RANDOM; i++) begin
      return_ar_credit();
      send_one_ar();
    end

    // 4: R beats within far-end credit, random rready
    sent   = 0;
    cycles = 0;
    while ((sent < R_BEATS || r_pops < R_BEATS) && cycles < R_LOOP_LIMIT) begin
      @(posedge clk_wr);
      cycles++;
      rready <= 1'(rand_bits(1));
      if (sent < R_BEATS && far_r_credit > 0 && rand_bits(1) == 1) begin
        send_random_r_beat();
        sent++;
      end else begin
        rx_phy <= '0;
      end
    end
    rready <= 1'b0;
    if (r_pops < R_BEATS) begin
      report_problem("Not all R beats came out before the loop limit");
    end
    repeat (3) @(negedge clk_wr);
    if (r_creds != r_pops || far_r_credit != R_FIFO_DEPTH) begin
      report_mismatch($sformatf("%0d R credits for %0d pops", r_creds, r_pops));
    end

    // 5: link drop with a credit and two beats pending
    return_ar_credit();
    @(posedge clk_wr);
    send_random_r_beat();
    @(posedge clk_wr);
    send_random_r_beat();
    @(posedge clk_wr);
    rx_phy <= '0;
    repeat (3) @(negedge clk_wr);
    if (!(arready && rvalid)) begin
      report_problem("arready and rvalid were not both high before the link drop");
    end
    @(posedge clk_wr);
    rx_online <= 1'b0;
    repeat (2) @(negedge clk_wr);
    if (arready !== 1'b0 || rvalid !== 1'b0) begin
      report_mismatch("arready or rvalid still high after rx_online fell");
    end
    // FIFO contents are lost and the far end starts over
    @(posedge clk_wr);
    exp_r.delete();
    far_r_credit    = R_FIFO_DEPTH;
    init_ar_credit <= CRED_W'(2);
    rx_online      <= 1'b1;
    waited = 0;
    @(negedge clk_wr);
    while (!arready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk_wr);
    end
    if (!arready) begin
      report_problem("The link did not come back up");
    end
    if (rvalid !== 1'b0) begin
      report_mismatch("rvalid high after relink, FIFO kept old beats");
    end
    stream_ar(8, taken);
    if (taken != 2) begin
      report_mismatch($sformatf("%0d requests taken after reload to 2", taken));
    end

    repeat (4) @(negedge clk_wr);
    if (exp_ar.size() != 0) begin
      report_problem("Accepted AR requests are still waiting for tx_phy");
    end
    $display("Mismatches: %0d, other errors: %0d", mismatches, problems);
    if (mismatches == 0 && problems == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_NS);
    $display("Watchdog expired after %0d cycles and the run did not finish", RUN_CYCLES);
    $display("Mismatches: %0d, other errors: %0d", mismatches, problems);
    $display("Errors found");
    $finish;
  end

endmodule

// File: tests/packet_master_checker.sv
/*
  Concurrent assertions for the packet master
  AR credit gating, R FIFO overflow, R valid after the link is down
  Bound into packet_master_top
*/
`timescale 1ns/1ps

module packet_master_checker (
  input logic                      clk_wr,
  input logic                      rst_n,
  input logic                      link_up,
  input logic [ll_pkg::CRED_W-1:0] credit_avail,
  input logic                      ar_push,
  input logic                      r_push,
  input logic                      fifo_full,
  input logic                      rvalid
);

  // No credit at an edge means nothing leaves in the next cycle
  ar_needs_credit: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (credit_avail == '0) |=> !ar_push)
    else $error("AR word sent with zero credit");

  r_fifo_no_overflow: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (r_push && link_up) |-> !fifo_full)
    else $error("R beat arrived while the FIFO was full");

  // A cycle with the link down leaves the FIFO flushed
  rvalid_needs_link: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !link_up |=> !rvalid)
    else $error("rvalid high after a cycle with the link down");

endmodule

bind packet_master_top packet_master_checker u_checker (
  .clk_wr       (clk_wr),
  .rst_n        (rst_n),
  .link_up      (link_up),
  .credit_avail (u_ar_tx.credit_avail),
  .ar_push      (ar_push),
  .r_push       (r_push),
  .fifo_full    (u_r_rx.fifo_full),
  .rvalid       (rvalid)
);

// File: tests/tb_clock.sv
/*
  Free-running testbench clock
  4 ns period, starts low
*/
`timescale 1ns/1ps

module tb_clock (
  output logic clk_wr
);
  localparam int HALF_NS = 2;

  initial begin
    clk_wr = 1'b0;
    forever #HALF_NS clk_wr = ~clk_wr;
  end

endmodule

// File: source/packet_master_top.sv
/*
  Packet master top level
  Link sequencer, AR transmit channel, R receive channel
  and the PHY word packer
*/
`timescale 1ns/1ps

module packet_master_top (
  input  logic                       clk_wr,
  input  logic                       rst_n,

  // Link control
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic [ll_pkg::DELAY_W-1:0] delay_value,
  input  logic [ll_pkg::CRED_W-1:0]  init_ar_credit,

  // AR channel
  input  logic [ll_pkg::ID_W-1:0]    arid,
  input  logic [ll_pkg::SIZE_W-1:0]  arsize,
  input  logic [ll_pkg::LEN_W-1:0]   arlen,
  input  logic [ll_pkg::BURST_W-1:0] arburst,
  input  logic [ll_pkg::ADDR_W-1:0]  araddr,
  input  logic                       arvalid,
  output logic                       arready,

  // R channel
  output logic [ll_pkg::ID_W-1:0]    rid,
  output logic [ll_pkg::DATA_W-1:0]  rdata,
  output logic                       rlast,
  output logic [ll_pkg::RESP_W-1:0]  rresp,
  output logic                       rvalid,
  input  logic                       rready,

  // PHY words
  output logic [ll_pkg::PHY_W-1:0]   tx_phy,
  input  logic [ll_pkg::PHY_W-1:0]   rx_phy
);
  import ll_pkg::*;

  //////////////////////////////////////////////////
  // Internal wires
  logic            link_up;
  logic            ar_push;
  logic [AR_W-1:0] ar_word;
  logic            ar_cred_in;
  logic            r_push;
  logic [R_W-1:0]  r_word;
  logic            r_cred_out;

  link_online_seq u_seq (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online),
    .rx_online   (rx_online),
    .delay_value (delay_value),
    .link_up     (link_up)
  );

  ll_credit_tx u_ar_tx (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .init_credit (init_ar_credit),
    .arid        (arid),
    .arsize      (arsize),
    .arlen       (arlen),
    .arburst     (arburst),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar_cred_in  (ar_cred_in),
    .ar_push     (ar_push),
    .ar_word     (ar_word)
  );

  ll_rx_fifo u_r_rx (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .link_up    (link_up),
    .r_push     (r_push),
    .r_word     (r_word),
    .rid        (rid),
    .rdata      (rdata),
    .rlast      (rlast),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .r_cred_out (r_cred_out)
  );

  phy_word_pack u_pack (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .ar_push    (ar_push),
    .ar_word    (ar_word),
    .r_cred_out (r_cred_out),
    .tx_phy     (tx_phy),
    .rx_phy     (rx_phy),
    .r_push     (r_push),
    .r_word     (r_word),
    .ar_cred_in (ar_cred_in)
  );

endmodule

// File: source/phy_word_pack.sv
/*
  PHY word packer
  Builds tx_phy from the AR word, AR pushbit and R credit
  Registers rx_phy and splits out the R word, R pushbit and AR credit
*/
`timescale 1ns/1ps

module phy_word_pack (
  input  logic                     clk_wr,
  input  logic                     rst_n,

  // Outgoing fields
  input  logic                     ar_push,
  input  logic [ll_pkg::AR_W-1:0]  ar_word,
  input  logic                     r_cred_out,
  output logic [ll_pkg::PHY_W-1:0] tx_phy,

  // Incoming fields
  input  logic [ll_pkg::PHY_W-1:0] rx_phy,
  output logic                     r_push,
  output logic [ll_pkg::R_W-1:0]   r_word,
  output logic                     ar_cred_in
);
  import ll_pkg::*;

  logic r_cred_q;

  //////////////////////////////////////////////////
  // TX word

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      r_cred_q <= 1'b0;
    end else begin
      r_cred_q <= r_cred_out;
    end
  end

  // AR fields come in registered, so only the credit needs a flop here
  always_comb begin
    tx_phy                 = '0;
    tx_phy[TX_AR_PUSH_BIT] = ar_push;
    tx_phy[TX_R_CRED_BIT]  = r_cred_q;
    // Payload bits stay zero on idle cycles
    if (ar_push) begin
      tx_phy[TX_AR_LSB +: AR_W] = ar_word;
    end
  end

  //////////////////////////////////////////////////
  // RX word

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      r_push     <= 1'b0;
      ar_cred_in <= 1'b0;
    end else begin
      r_push     <= rx_phy[RX_R_PUSH_BIT];
      ar_cred_in <= rx_phy[RX_AR_CRED_BIT];
    end
  end

  always_ff @(posedge clk_wr) begin
    r_word <= rx_phy[RX_R_LSB +: R_W];
  end

endmodule

// File: source/ll_rx_fifo.sv
/*
  R receive channel
  Circular buffer of R beats from the far end
  Head entry presented on the user R ports with valid/ready
  One credit pulse back to the far end per beat popped
*/
`timescale 1ns/1ps

module ll_rx_fifo (
  input  logic                      clk_wr,
  input  logic                      rst_n,
  input  logic                      link_up,

  // Link side
  input  logic                      r_push,
  input  logic [ll_pkg::R_W-1:0]    r_word,

  // User R channel
  output logic [ll_pkg::ID_W-1:0]   rid,
  output logic [ll_pkg::DATA_W-1:0] rdata,
  output logic                      rlast,
  output logic [ll_pkg::RESP_W-1:0] rresp,
  output logic                      rvalid,
  input  logic                      rready,

  output logic                      r_cred_out
);
  import ll_pkg::*;

  logic [R_W-1:0]   fifo_mem [R_FIFO_DEPTH];
  // One extra pointer bit tells full from empty
  logic [R_PTR_W:0] wr_ptr;
  logic [R_PTR_W:0] rd_ptr;
  logic [R_PTR_W:0] fill;
  logic             fifo_empty;
  logic             fifo_full;
  logic             fifo_wr;
  logic             fifo_rd;

  //////////////////////////////////////////////////
  // Status and handshake

  assign fill       = wr_ptr - rd_ptr;
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (fill == (R_PTR_W + 1)'(R_FIFO_DEPTH));

  assign fifo_wr = r_push & link_up & ~fifo_full;
  assign rvalid  = link_up & ~fifo_empty;
  assign fifo_rd = rvalid & rready;

  // Every pop frees one slot at the far end
  assign r_cred_out = fifo_rd;

  //////////////////////////////////////////////////
  // Pointers and storage

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!link_up) begin
      // Flush while the link is down
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (fifo_wr) begin
      fifo_mem[wr_ptr[R_PTR_W-1:0]] <= r_word;
    end
  end

  // Head entry unpack
  assign {rid, rdata, rlast, rresp} = fifo_mem[rd_ptr[R_PTR_W-1:0]];

endmodule

// File: source/ll_credit_tx.sv
/*
  AR transmit channel
  Valid/ready acceptance gated by the far-end credit count
  Registered AR payload word and pushbit toward the PHY packer
*/
`timescale 1ns/1ps

module ll_credit_tx (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       link_up,
  input  logic [ll_pkg::CRED_W-1:0]  init_credit,

  // User AR channel
  input  logic [ll_pkg::ID_W-1:0]    arid,
  input  logic [ll_pkg::SIZE_W-1:0]  arsize,
  input  logic [ll_pkg::LEN_W-1:0]   arlen,
  input  logic [ll_pkg::BURST_W-1:0] arburst,
  input  logic [ll_pkg::ADDR_W-1:0]  araddr,
  input  logic                       arvalid,
  output logic                       arready,

  // Link side
  input  logic                       ar_cred_in,
  output logic                       ar_push,
  output logic [ll_pkg::AR_W-1:0]    ar_word
);
  import ll_pkg::*;

  logic              link_up_q;
  logic              link_rise;
  logic [CRED_W-1:0] credit_cnt;
  logic [CRED_W-1:0] credit_avail;
  logic              ar_accept;

  //////////////////////////////////////////////////
  // Credit tracking

  // Initial credit is usable in the very cycle the link comes up
  assign link_rise    = link_up & ~link_up_q;
  assign credit_avail = link_rise ? init_credit : credit_cnt;

  assign arready   = link_up & (credit_avail != '0);
  assign ar_accept = arvalid & arready;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      link_up_q  <= 1'b0;
      credit_cnt <= '0;
    end else begin
      link_up_q <= link_up;
      if (!link_up) begin
        credit_cnt <= '0;
      end else begin
        // Send and return may land in the same cycle
        credit_cnt <= credit_avail - CRED_W'(ar_accept) + CRED_W'(ar_cred_in);
      end
    end
  end

  //////////////////////////////////////////////////
  // Outgoing AR word

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ar_push <= 1'b0;
    end else begin
      ar_push <= ar_accept;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (ar_accept) begin
      ar_word <= {arid, arsize, arlen, arburst, araddr};
    end
  end

endmodule

// File: source/link_online_seq.sv
/*
  Link-online sequencer
  Raises link_up once both sides are online and the delay has run out
*/
`timescale 1ns/1ps

module link_online_seq (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic [ll_pkg::DELAY_W-1:0] delay_value,
  output logic                       link_up
);
  import ll_pkg::*;

  link_state_e        state;
  logic [DELAY_W-1:0] delay_cnt;
  logic               both_online;

  assign both_online = tx_online & rx_online;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      state     <= LINK_OFFLINE;
      delay_cnt <= '0;
    end else if (!both_online) begin
      // Either side dropping takes the link down at once
      state     <= LINK_OFFLINE;
      delay_cnt <= '0;
    end else begin
      case (state)
        LINK_OFFLINE: begin
          state     <= LINK_WAIT;
          delay_cnt <= delay_value;
        end
        LINK_WAIT: begin
          if (delay_cnt == '0) begin
            state <= LINK_ONLINE;
          end else begin
            delay_cnt <= delay_cnt - DELAY_W'(1);
          end
        end
        default: state <= LINK_ONLINE;
      endcase
    end
  end

  assign link_up = (state == LINK_ONLINE);

endmodule

// File: source/ll_pkg.sv
/*
  Shared definitions for the logic-link packet master
  AXI read field widths and payload word widths
  PHY word bit map for both directions, R FIFO depth
  Link sequencer state type
*/
package ll_pkg;

  //////////////////////////////////////////////////
  // AXI read fields
  localparam int ID_W    = 4;
  localparam int ADDR_W  = 48;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;
  localparam int DATA_W  = 64;

  // AR payload, high to low: id, size, len, burst, addr
  localparam int AR_W = ID_W + SIZE_W + LEN_W + BURST_W + ADDR_W;
  // R payload, high to low: id, data, last, resp
  localparam int R_W  = ID_W + DATA_W + 1 + RESP_W;

  //////////////////////////////////////////////////
  // Link parameters
  localparam int PHY_W        = 80;
  localparam int CRED_W       = 8;
  localparam int DELAY_W      = 16;

  // Also the R credit the far end starts with
  localparam int R_FIFO_DEPTH = 8;
  localparam int R_PTR_W      = $clog2(R_FIFO_DEPTH);

  //////////////////////////////////////////////////
  // Outgoing PHY word
  localparam int TX_AR_PUSH_BIT = 0;
  localparam int TX_R_CRED_BIT  = 1;
  localparam int TX_AR_LSB      = 2;

  // Incoming PHY word
  localparam int RX_R_PUSH_BIT  = 0;
  localparam int RX_AR_CRED_BIT = 1;
  localparam int RX_R_LSB       = 2;

  // Link sequencer states
  typedef enum logic [1:0] {
    LINK_OFFLINE,
    LINK_WAIT,
    LINK_ONLINE
  } link_state_e;

endpackage
